// ==== Makefile ====
# Verilator build and run for the DZ transmit block testbench

VERILATOR ?= verilator
TOP       ?= tbDz
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASSMSG   ?= TEST OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJDIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)

// ==== dzApbCtrl.sv ====
// APB4 slave front end for the DZ register block
// Setup tracking so each transfer acts once
// Write strobes and byte lanes for CSR, TCR and TDR
// Read multiplexer and error response
`timescale 1ns/10ps
`default_nettype none

module dzApbCtrl (
   input  wire         clk,
   input  wire         rst,
   input  wire         psel,
   input  wire         penable,
   input  wire         pwrite,
   input  wire  [3:0]  paddr,
   input  wire  [15:0] pwdata,
   input  wire  [1:0]  pstrb,
   input  wire  [15:0] csrValue,
   input  wire  [15:0] tcrValue,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr,
   output logic        csrWrite,
   output logic        tcrWrite,
   output logic        tdrWrite,
   output logic        loByte,
   output logic        hiByte,
   output logic [15:0] wrData
);

   logic isCsr;
   logic isTcr;
   logic isTdr;
   logic mapped;
   logic armed;
   logic wrAccess;

   // Offset decode
   assign isCsr  = (paddr == dzPkg::csrOffset);
   assign isTcr  = (paddr == dzPkg::tcrOffset);
   assign isTdr  = (paddr == dzPkg::tdrOffset);
   assign mapped = isCsr | isTcr | isTdr;

   // Never stall, zero wait states
   assign pready = 1'b1;

   ////////////////////////////////////////
   // Phase tracking
   ////////////////////////////////////////

   // Armed by SETUP, consumed by ACCESS
   // Error flag lines up with the ACCESS cycle
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         armed   <= 1'b0;
         pslverr <= 1'b0;
      end
      else
      begin
         armed   <= psel & ~penable;
         pslverr <= psel & ~penable & ~mapped;
      end
   end

   // Write in ACCESS, acted on at its closing edge
   assign wrAccess = psel & penable & pwrite & armed;

   ////////////////////////////////////////
   // Write strobes
   ////////////////////////////////////////

   assign csrWrite = wrAccess & isCsr;
   assign tcrWrite = wrAccess & isTcr;
   assign tdrWrite = wrAccess & isTdr;

   // Lane 0 low byte, lane 1 high byte
   assign loByte = wrAccess & pstrb[0];
   assign hiByte = wrAccess & pstrb[1];
   assign wrData = pwdata;

   // Read mux, upper half always zero
   always_comb
   begin
      prdata = '0;
      if (psel & penable & ~pwrite)
      begin
         if (isCsr)
            prdata[15:0] = csrValue;
         else if (isTcr)
            prdata[15:0] = tcrValue;
         // TDR is write only and reads zero
      end
   end

endmodule

`default_nettype wire

// ==== dzCsr.sv ====
// CSR control bits for the transmit block
// Scan enable, interrupt enable, one-cycle clear pulse
// Read value assembly and registered interrupt
`timescale 1ns/10ps
`default_nettype none

module dzCsr (
   input  wire         clk,
   input  wire         rst,
   input  wire         devReset,
   input  wire         csrWrite,
   input  wire         loByte,
   input  wire         hiByte,
   input  wire  [15:0] wrData,
   input  wire         trdy,
   input  wire  [2:0]  tline,
   output logic        csrClr,
   output logic        mse,
   output logic [15:0] csrValue,
   output logic        irq
);

   logic tie;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         mse    <= 1'b0;
         tie    <= 1'b0;
         csrClr <= 1'b0;
         irq    <= 1'b0;
      end
      else
      begin
         // Pulse lasts a single cycle
         csrClr <= 1'b0;
         // Interrupt trails transmit ready by one cycle
         irq    <= trdy & tie;
         if (devReset | csrClr)
         begin
            mse <= 1'b0;
            tie <= 1'b0;
         end
         else if (csrWrite)
         begin
            if (loByte)
            begin
               mse    <= wrData[dzPkg::csrMseBit];
               csrClr <= wrData[dzPkg::csrClrBit];
            end
            if (hiByte)
               tie <= wrData[dzPkg::csrTieBit];
         end
      end
   end

   // Own bits plus scanner status
   always_comb
   begin
      csrValue = '0;
      csrValue[dzPkg::csrClrBit] = csrClr;
      csrValue[dzPkg::csrMseBit] = mse;
      csrValue[dzPkg::csrTlineLsb +: dzPkg::lineW] = tline;
      csrValue[dzPkg::csrTieBit] = tie;
      csrValue[dzPkg::csrTrdyBit] = trdy;
   end

endmodule

`default_nettype wire

// ==== dzPkg.sv ====
// Shared definitions for the DZ11-style transmit register block
// Line count and line number width
// APB register offsets and CSR field positions
// Scanner state encoding
`default_nettype none

package dzPkg;

   ////////////////////////////////////////
   // Line geometry
   ////////////////////////////////////////

   // Eight serial lines per multiplexer
   localparam int numLines = 8;

   // Bits needed to name one line
   localparam int lineW = 3;

   ////////////////////////////////////////
   // Register map
   ////////////////////////////////////////

   // Byte offsets, low four address bits only
   localparam logic [3:0] csrOffset = 4'h0;
   localparam logic [3:0] tcrOffset = 4'h4;
   localparam logic [3:0] tdrOffset = 4'h8;

   ////////////////////////////////////////
   // CSR fields
   ////////////////////////////////////////

   // Self-clearing clear request, low byte
   localparam int csrClrBit = 4;

   // Master scan enable, low byte
   localparam int csrMseBit = 5;

   // Transmit line field, three bits starting here
   localparam int csrTlineLsb = 8;

   // Transmit interrupt enable, high byte
   localparam int csrTieBit = 14;

   // Transmit ready status, read only
   localparam int csrTrdyBit = 15;

   // Scanner states
   typedef enum logic [1:0] {
      scanIdle,
      scanSearch,
      scanReady,
      scanSend
   } ScanState;

endpackage

`default_nettype wire

// ==== dzTcr.sv ====
// Transmit control register
// Low byte line enables, high byte data terminal ready
// Byte-lane writes, clear and device reset handling
`timescale 1ns/10ps
`default_nettype none

module dzTcr (
   input  wire         clk,
   input  wire         rst,
   input  wire         devReset,
   input  wire         csrClr,
   input  wire         tcrWrite,
   input  wire         loByte,
   input  wire         hiByte,
   input  wire  [15:0] wrData,
   output logic [15:0] tcrValue
);

   logic [7:0] lineEn;
   logic [7:0] dtr;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         lineEn <= '0;
         dtr    <= '0;
      end
      else if (devReset)
      begin
         // Bus reset drops everything
         lineEn <= '0;
         dtr    <= '0;
      end
      else if (csrClr)
      begin
         // DTR survives a CSR clear
         lineEn <= '0;
      end
      else if (tcrWrite)
      begin
         if (loByte)
            lineEn <= wrData[7:0];
         if (hiByte)
            dtr <= wrData[15:8];
      end
   end

   assign tcrValue = {dtr, lineEn};

endmodule

`default_nettype wire

// ==== dzTop.sv ====
// Top level of the DZ transmit register block
// APB front end, CSR, TCR and line scanner
// Transmit port and interrupt request
`timescale 1ns/10ps
`default_nettype none

module dzTop (
   input  wire         clk,
   input  wire         rst,
   input  wire         devReset,
   input  wire         psel,
   input  wire         penable,
   input  wire         pwrite,
   input  wire  [3:0]  paddr,
   input  wire  [31:0] pwdata,
   input  wire  [3:0]  pstrb,
   output logic [31:0] prdata,
   output logic        pready,
   output logic        pslverr,
   output logic        txValid,
   output logic [2:0]  txLine,
   output logic [7:0]  txData,
   input  wire         txReady,
   output logic        irq
);

   // Bus side strobes
   logic        csrWrite;
   logic        tcrWrite;
   logic        tdrWrite;
   logic        loByte;
   logic        hiByte;
   logic [15:0] wrData;

   // Register values and status
   logic [15:0] csrValue;
   logic [15:0] tcrValue;
   logic        csrClr;
   logic        mse;
   logic        trdy;
   logic [2:0]  tline;

   ////////////////////////////////////////
   // Bus interface
   ////////////////////////////////////////

   // Only the low half word and lanes 0 and 1 carry register data
   dzApbCtrl u_dzApbCtrl (
      .clk      (clk),
      .rst      (rst),
      .psel     (psel),
      .penable  (penable),
      .pwrite   (pwrite),
      .paddr    (paddr),
      .pwdata   (pwdata[15:0]),
      .pstrb    (pstrb[1:0]),
      .csrValue (csrValue),
      .tcrValue (tcrValue),
      .prdata   (prdata),
      .pready   (pready),
      .pslverr  (pslverr),
      .csrWrite (csrWrite),
      .tcrWrite (tcrWrite),
      .tdrWrite (tdrWrite),
      .loByte   (loByte),
      .hiByte   (hiByte),
      .wrData   (wrData)
   );

   ////////////////////////////////////////
   // Registers and scanner
   ////////////////////////////////////////

   dzCsr u_dzCsr (
      .clk      (clk),
      .rst      (rst),
      .devReset (devReset),
      .csrWrite (csrWrite),
      .loByte   (loByte),
      .hiByte   (hiByte),
      .wrData   (wrData),
      .trdy     (trdy),
      .tline    (tline),
      .csrClr   (csrClr),
      .mse      (mse),
      .csrValue (csrValue),
      .irq      (irq)
   );

   dzTcr u_dzTcr (
      .clk      (clk),
      .rst      (rst),
      .devReset (devReset),
      .csrClr   (csrClr),
      .tcrWrite (tcrWrite),
      .loByte   (loByte),
      .hiByte   (hiByte),
      .wrData   (wrData),
      .tcrValue (tcrValue)
   );

   // Line enables come from the TCR low byte
   dzTxScan u_dzTxScan (
      .clk        (clk),
      .rst        (rst),
      .devReset   (devReset),
      .csrClr     (csrClr),
      .mse        (mse),
      .lineEnable (tcrValue[7:0]),
      .tdrWrite   (tdrWrite),
      .loByte     (loByte),
      .wrData     (wrData[7:0]),
      .txReady    (txReady),
      .trdy       (trdy),
      .tline      (tline),
      .txValid    (txValid),
      .txLine     (txLine),
      .txData     (txData)
   );

endmodule

`default_nettype wire

// ==== dzTxScan.sv ====
// Transmit line scanner
// Round-robin search over enabled lines
// Transmit ready and line status for the CSR
// TDR capture and valid/ready output handshake
`timescale 1ns/10ps
`default_nettype none

module dzTxScan (
   input  wire                        clk,
   input  wire                        rst,
   input  wire                        devReset,
   input  wire                        csrClr,
   input  wire                        mse,
   input  wire  [dzPkg::numLines-1:0] lineEnable,
   input  wire                        tdrWrite,
   input  wire                        loByte,
   input  wire  [7:0]                 wrData,
   input  wire                        txReady,
   output logic                       trdy,
   output logic [2:0]                 tline,
   output logic                       txValid,
   output logic [2:0]                 txLine,
   output logic [7:0]                 txData
);

   dzPkg::ScanState state;

   // Line under examination and held while ready or sending
   logic [dzPkg::lineW-1:0] ptr;

   logic take;

   // Character accepted only while offering a line
   assign take = (state == dzPkg::scanReady) & tdrWrite & loByte;

   ////////////////////////////////////////
   // Scanner FSM
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state <= dzPkg::scanIdle;
         ptr   <= '0;
      end
      else if (devReset | csrClr)
      begin
         // Pending character is abandoned
         state <= dzPkg::scanIdle;
      end
      else
      begin
         unique case (state)
            dzPkg::scanIdle:
               if (mse)
                  state <= dzPkg::scanSearch;
            dzPkg::scanSearch:
               if (!mse)
                  state <= dzPkg::scanIdle;
               else if (lineEnable[ptr])
                  state <= dzPkg::scanReady;
               else
                  ptr <= ptr + 3'd1;
            dzPkg::scanReady:
               if (take)
                  state <= dzPkg::scanSend;
            dzPkg::scanSend:
               if (txReady)
               begin
                  // Resume after the line just served and wrap at eight
                  ptr   <= ptr + 3'd1;
                  state <= dzPkg::scanSearch;
               end
            default:
               state <= dzPkg::scanIdle;
         endcase
      end
   end

   // Character register
   always_ff @(posedge clk)
   begin
      if (take)
         txData <= wrData;
   end

   // Status and output port
   assign trdy    = (state == dzPkg::scanReady);
   assign txValid = (state == dzPkg::scanSend);
   assign tline   = ptr;
   assign txLine  = ptr;

endmodule

`default_nettype wire

// ==== tbDz.sv ====
// Testbench for the DZ transmit register block
// Clock, reset, APB read and write tasks, LCG stimulus
// Reference line scan, transmit port checker, cycle watchdog
`timescale 1ns/10ps
`default_nettype none

module tbDz;

   localparam int maxCycles = 20000;
   localparam logic [31:0] seed = 32'had0c_6fe9;
   localparam logic [15:0] csrRun = 16'(1 << dzPkg::csrMseBit) | 16'(1 << dzPkg::csrTieBit);
   localparam logic [15:0] trdyMask = 16'(1 << dzPkg::csrTrdyBit);
   localparam logic [15:0] clrMask = 16'(1 << dzPkg::csrClrBit);

   logic        clk;
   logic        rst;
   logic        devReset;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [3:0]  paddr;
   logic [31:0] pwdata;
   logic [3:0]  pstrb;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic        txValid;
   logic [2:0]  txLine;
   logic [7:0]  txData;
   logic        txReady;
   logic        irq;

   int          errors;
   int          checks;
   int          cycles;
   logic [31:0] rngState;
   logic [31:0] bpState;
   logic        err;
   logic [31:0] rdata;
   logic [15:0] wdata;
   logic [15:0] tcrModel;
   logic [7:0]  mask;
   logic [2:0]  line;
   logic [2:0]  prevLine;
   logic [10:0] entry;

   // Expected characters with the line in the top three bits
   logic [10:0] expQ [$];

   dzTop u_dzTop (
      .clk      (clk),
      .rst      (rst),
      .devReset (devReset),
      .psel     (psel),
      .penable  (penable),
      .pwrite   (pwrite),
      .paddr    (paddr),
      .pwdata   (pwdata),
      .pstrb    (pstrb),
      .prdata   (prdata),
      .pready   (pready),
      .pslverr  (pslverr),
      .txValid  (txValid),
      .txLine   (txLine),
      .txData   (txData),
      .txReady  (txReady),
      .irq      (irq)
   );

   // 40 ns period
   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] lcg(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // First enabled line after the given one in wrapping order
   function automatic logic [2:0] nextLine(input logic [2:0] after, input logic [7:0] en);
      logic [2:0] cand;
      logic [2:0] found;
      found = after;
      for (int i = 8; i >= 1; i--)
      begin
         cand = after + i[2:0];
         if (en[cand])
            found = cand;
      end
      return found;
   endfunction

   task automatic compareValue(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("Error at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      end
   endtask

   task automatic apbWrite(input logic [3:0] addr, input logic [15:0] data,
                           input logic [1:0] strb, output logic slvErr);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= {16'h0, data};
      pstrb   <= {2'b00, strb};
      @(posedge clk);
      penable <= 1'b1;
      // Sample in mid ACCESS away from the edge
      @(negedge clk);
      slvErr = pslverr;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic apbRead(input logic [3:0] addr, output logic [31:0] data,
                          output logic slvErr);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      pstrb   <= 4'h0;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);
      data   = prdata;
      slvErr = pslverr;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic checkRead(input logic [3:0] addr, input logic [15:0] exp, input string name);
      logic [31:0] data;
      logic        slvErr;
      apbRead(addr, data, slvErr);
      compareValue(name, data, 32'(exp));
      compareValue("pslverr", 32'(slvErr), 32'd0);
   endtask

   // Read CSR until a line is offered and expect irq to follow
   task automatic pollReady(output logic [2:0] found);
      logic [31:0] val;
      logic        slvErr;
      val = 32'd0;
      while (!val[dzPkg::csrTrdyBit])
      begin
         apbRead(dzPkg::csrOffset, val, slvErr);
      end
      found = val[dzPkg::csrTlineLsb +: 3];
      @(negedge clk);
      compareValue("irq", 32'(irq), 32'd1);
   endtask

   task automatic finishRun;
      $display("Checks run %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   endtask

   ////////////////////////////////////////
   // Back-pressure and checker
   ////////////////////////////////////////

   // Ready about three cycles in four
   initial
   begin
      txReady = 1'b0;
      bpState = seed;
      forever
      begin
         @(posedge clk);
         bpState = lcg(bpState);
         txReady <= (bpState[27:26] != 2'b00);
      end
   end

   // Handshake seen at negedge completes on the next rising edge
   initial
   begin
      forever
      begin
         @(negedge clk);
         if (!rst && !devReset && txValid && txReady)
         begin
            if (expQ.size() == 0)
            begin
               errors++;
               $display("Error at %0t ns: character sent on line %0d with no TDR write behind it",
                        $time, txLine);
            end
            else
            begin
               entry = expQ.pop_front();
               compareValue("txLine", 32'(txLine), 32'(entry[10:8]));
               compareValue("txData", 32'(txData), 32'(entry[7:0]));
            end
         end
      end
   end

   // Watchdog sized for 64 characters at up to ~300 cycles each
   initial
   begin
      while (cycles < maxCycles)
      begin
         @(posedge clk);
         cycles++;
      end
      errors++;
      $display("Timeout: run did not finish within %0d clock cycles", maxCycles);
      finishRun();
   end

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial
   begin
      rst      = 1'b1;
      devReset = 1'b0;
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      paddr    = 4'h0;
      pwdata   = 32'h0;
      pstrb    = 4'h0;
      rngState = seed;
      repeat (10) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);

      // Reset values
      compareValue("txValid", 32'(txValid), 32'd0);
      compareValue("irq", 32'(irq), 32'd0);
      checkRead(dzPkg::csrOffset, 16'h0, "CSR");
      checkRead(dzPkg::tcrOffset, 16'h0, "TCR");

      // Every lane combination against the model
      tcrModel = 16'h0;
      for (int s = 0; s < 8; s++)
      begin
         rngState = lcg(rngState);
         wdata = rngState[23:8];
         apbWrite(dzPkg::tcrOffset, wdata, s[1:0], err);
         if (s[0])
            tcrModel[7:0] = wdata[7:0];
         if (s[1])
            tcrModel[15:8] = wdata[15:8];
         checkRead(dzPkg::tcrOffset, tcrModel, "TCR");
      end

      // Unmapped offset errors out and leaves registers alone
      apbWrite(4'hC, 16'hFFEF, 2'b11, err);
      compareValue("pslverr", 32'(err), 32'd1);
      apbRead(4'hC, rdata, err);
      compareValue("pslverr", 32'(err), 32'd1);
      checkRead(dzPkg::tcrOffset, tcrModel, "TCR");
      checkRead(dzPkg::csrOffset, 16'h0, "CSR");
      checkRead(dzPkg::tdrOffset, 16'h0, "TDR");

      // TDR write with scanner idle goes nowhere
      apbWrite(dzPkg::tdrOffset, 16'h0055, 2'b01, err);
      repeat (20) @(posedge clk);
      compareValue("txValid", 32'(txValid), 32'd0);

      // Line 0 is enabled so the offer stays on line 0
      apbWrite(dzPkg::tcrOffset, 16'hA5C3, 2'b11, err);
      apbWrite(dzPkg::csrOffset, csrRun, 2'b11, err);
      checkRead(dzPkg::csrOffset, csrRun | trdyMask, "CSR");
      apbWrite(dzPkg::csrOffset, clrMask, 2'b01, err);
      checkRead(dzPkg::csrOffset, 16'h0, "CSR");
      checkRead(dzPkg::tcrOffset, 16'hA500, "TCR");
      // Line enables and scanning back on ahead of device reset
      apbWrite(dzPkg::tcrOffset, 16'h00C3, 2'b01, err);
      apbWrite(dzPkg::csrOffset, csrRun, 2'b11, err);
      @(posedge clk);
      devReset <= 1'b1;
      @(posedge clk);
      devReset <= 1'b0;
      checkRead(dzPkg::tcrOffset, 16'h0, "TCR");
      checkRead(dzPkg::csrOffset, 16'h0, "CSR");

      // Eight rounds of eight characters with a new mask each round
      prevLine = 3'd7;
      for (int r = 0; r < 8; r++)
      begin
         rngState = lcg(rngState);
         mask = rngState[23:16];
         if (mask == 8'h0)
            mask = 8'h01;
         apbWrite(dzPkg::tcrOffset, {8'h0, mask}, 2'b01, err);
         apbWrite(dzPkg::csrOffset, csrRun, 2'b11, err);
         for (int k = 0; k < 8; k++)
         begin
            pollReady(line);
            compareValue("tline", 32'(line), 32'(nextLine(prevLine, mask)));
            rngState = lcg(rngState);
            apbWrite(dzPkg::tdrOffset, {8'h0, rngState[15:8]}, 2'b01, err);
            expQ.push_back({line, rngState[15:8]});
            prevLine = line;
         end
         while (expQ.size() != 0)
         begin
            @(posedge clk);
         end
         // Clear while offering keeps the pointer on the offered line
         pollReady(line);
         compareValue("tline", 32'(line), 32'(nextLine(prevLine, mask)));
         apbWrite(dzPkg::csrOffset, clrMask, 2'b01, err);
         prevLine = line - 3'd1;
      end

      repeat (10) @(posedge clk);
      compareValue("txValid", 32'(txValid), 32'd0);
      finishRun();
   end

endmodule

`default_nettype wire

// ==== tbDz_assertions.sv ====
// Bound checks on the DZ transmit block
// Transmit port holds steady under back-pressure
// Ready status and valid never overlap, APB never waits
`timescale 1ns/10ps
`default_nettype none

module tbDz_assertions (
   input wire       clk,
   input wire       rst,
   input wire       devReset,
   input wire       csrClr,
   input wire       trdy,
   input wire       pready,
   input wire       txValid,
   input wire       txReady,
   input wire [2:0] txLine,
   input wire [7:0] txData
);

   // Offered character stays put until taken, unless cleared
   assert property (@(posedge clk) disable iff (rst)
      (txValid && !txReady && !csrClr && !devReset)
      |=> (txValid && $stable(txLine) && $stable(txData)))
      else $error("transmit port changed before txReady");

   // Scanner offers a line or sends, never both
   assert property (@(posedge clk) disable iff (rst) !(trdy && txValid))
      else $error("transmit ready and txValid high together");

   // Zero wait states
   assert property (@(posedge clk) disable iff (rst) pready)
      else $error("pready went low");

endmodule

bind dzTop tbDz_assertions u_tbDz_assertions (
   .clk      (clk),
   .rst      (rst),
   .devReset (devReset),
   .csrClr   (csrClr),
   .trdy     (trdy),
   .pready   (pready),
   .txValid  (txValid),
   .txReady  (txReady),
   .txLine   (txLine),
   .txData   (txData)
);

`default_nettype wire

// ==== verilog.f ====
dzPkg.sv
dzApbCtrl.sv
dzCsr.sv
dzTcr.sv
dzTxScan.sv
dzTop.sv
tbDz_assertions.sv
tbDz.sv
